// ==== source/lsu_params.svh ====
// lsu parameters
// widths, outstanding depth and counter size of the load/store unit

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// bus geometry
`define LSU_ADDR_W 32   // byte address
`define LSU_DATA_W 32   // one bus word
`define LSU_BE_W   4    // one enable per byte lane

// outstanding transaction tracking
`define LSU_DEPTH  2    // max transactions in flight
`define LSU_CNT_W  2    // holds 0..LSU_DEPTH

`endif

// ==== source/lsu_pkg.sv ====
// lsu package
// access size, load extension mode and the two views of a bus word

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////
  // access size, code 11 decodes as byte as well
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  ////////////////////////////////////////////////////////////////////
  // load extension, code 11 behaves as sign extension
  typedef enum logic [1:0] {
    SEXT_ZERO = 2'b00,
    SEXT_SIGN = 2'b01,
    SEXT_ONES = 2'b10
  } sign_ext_e;

  ////////////////////////////////////////////////////////////////////
  // response word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0]  b;  // b[0] is the lowest address
    logic [1:0][15:0] h;  // h[0] covers bytes 1:0
  } lsu_word_u;

endpackage

// ==== source/lsu_req_ctrl.sv ====
// lsu request control
// address generation, split detection, outstanding count and stage handshakes

`include "lsu_params.svh"

module lsu_req_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   data_req_ex_i,        // EX wants a bus access
  input  lsu_pkg::data_type_e    data_type_ex_i,
  input  logic                   data_misaligned_ex_i, // second part of a split access
  input  logic [`LSU_ADDR_W-1:0] operand_a_ex_i,
  input  logic [`LSU_ADDR_W-1:0] operand_b_ex_i,
  input  logic                   addr_useincr_ex_i,    // a + b, else a only
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  output logic [`LSU_ADDR_W-1:0] addr_o,               // bus address
  output logic                   trans_valid_o,        // request towards the bus
  output logic                   misaligned_o,         // first part needs a second access
  output logic                   ready_ex_o,
  output logic                   ready_wb_o,
  output logic                   ctrl_update_o,        // EX moves into WB
  output logic                   busy_o
);

  import lsu_pkg::*;

  localparam logic [`LSU_CNT_W-1:0] DEPTH_C = `LSU_CNT_W'(`LSU_DEPTH);

  logic [`LSU_ADDR_W-1:0] addr_int;   // effective byte address
  logic [`LSU_CNT_W-1:0]  cnt_q;      // transactions in flight
  logic [`LSU_CNT_W-1:0]  next_cnt;
  logic                   count_up;
  logic                   count_down;

  //////////////////////////////////////////////////////////////////////
  // address

  assign addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;

  // second part always starts at the word boundary, leftover bytes sit low
  assign addr_o = data_misaligned_ex_i ? {addr_int[`LSU_ADDR_W-1:2], 2'b00} : addr_int;

  // only a first part can be split
  always_comb begin
    misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (data_type_ex_i)
        DT_WORD: misaligned_o = (addr_int[1:0] != 2'b00);  // any offset crosses
        DT_HALF: misaligned_o = (addr_int[1:0] == 2'b11);  // only the last lane
        default: misaligned_o = 1'b0;                      // bytes never cross
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request gate and stage handshakes

  // no rvalid in this path, request depends on the count only
  assign trans_valid_o = data_req_ex_i && (cnt_q < DEPTH_C);

  assign busy_o = (cnt_q != '0) || trans_valid_o;

  // WB free when idle, otherwise it retires with the response
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : rvalid_i;

  // EX and WB advance in lock step once WB holds something
  always_comb begin
    if (!data_req_ex_i) begin
      ready_ex_o = 1'b1;
    end else if (cnt_q == '0) begin
      ready_ex_o = trans_valid_o && gnt_i;
    end else if (cnt_q == `LSU_CNT_W'(1)) begin
      ready_ex_o = rvalid_i && trans_valid_o && gnt_i;
    end else begin
      ready_ex_o = rvalid_i;  // full, wait for a slot
    end
  end

  assign ctrl_update_o = ready_ex_o && data_req_ex_i;

  //////////////////////////////////////////////////////////////////////
  // outstanding counter

  assign count_up   = trans_valid_o && gnt_i;  // request taken
  assign count_down = rvalid_i;                // response retired

  always_comb begin
    case ({count_up, count_down})
      2'b10:   next_cnt = cnt_q + `LSU_CNT_W'(1);
      2'b01:   next_cnt = cnt_q - `LSU_CNT_W'(1);
      default: next_cnt = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= next_cnt;
    end
  end

endmodule

// ==== source/lsu_store_align.sv ====
// lsu store alignment
// byte enables per access size and rotation of store data into its lanes

`include "lsu_params.svh"

module lsu_store_align (
  input  logic [1:0]             addr_lsb_i,           // byte offset of the access
  input  lsu_pkg::data_type_e    data_type_ex_i,
  input  logic                   data_misaligned_ex_i, // second part of a split access
  input  logic [`LSU_DATA_W-1:0] data_wdata_ex_i,
  input  logic [1:0]             data_reg_offset_ex_i, // byte offset inside the register
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o
);

  import lsu_pkg::*;

  localparam logic [`LSU_BE_W-1:0] BE_ALL  = '1;
  localparam logic [`LSU_BE_W-1:0] BE_HALF = `LSU_BE_W'(2'b11);
  localparam logic [`LSU_BE_W-1:0] BE_ONE  = `LSU_BE_W'(1'b1);

  logic [1:0]               lane_shift;  // rotate amount in bytes
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;   // doubled word, upper half is the rotation

  //////////////////////////////////////////////////////////////////////
  // byte enables

  always_comb begin
    be_o = BE_ONE << addr_lsb_i;  // byte, and any code not listed below
    case (data_type_ex_i)
      DT_WORD: begin
        if (!data_misaligned_ex_i)
          be_o = BE_ALL << addr_lsb_i;     // lanes k..3
        else
          be_o = ~(BE_ALL << addr_lsb_i);  // leftover low lanes
      end
      DT_HALF: begin
        if (!data_misaligned_ex_i)
          be_o = BE_HALF << addr_lsb_i;    // offset 3 drops the upper bit
        else
          be_o = BE_ONE;                   // only lane 0 is left over
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // store data rotation

  // distance from the register byte to the memory lane, modulo 4
  assign lane_shift = addr_lsb_i - data_reg_offset_ex_i;

  // rotate left, bytes leaving the top come back in at lane 0
  assign wdata_dbl = {data_wdata_ex_i, data_wdata_ex_i} << {lane_shift, 3'b000};
  assign wdata_o   = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

// ==== source/lsu_load_align.sv ====
// lsu load alignment
// WB control registers, merge of split loads, lane select and extension

`include "lsu_params.svh"

module lsu_load_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ctrl_update_i,        // EX moves into WB
  input  lsu_pkg::data_type_e    data_type_ex_i,
  input  lsu_pkg::sign_ext_e     data_sign_ext_ex_i,
  input  logic                   data_we_ex_i,
  input  logic [1:0]             addr_lsb_i,           // byte offset of the access
  input  logic                   data_misaligned_ex_i, // second part sits in EX
  input  logic                   misaligned_i,         // first part just detected
  input  logic                   rvalid_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_ex_o
);

  import lsu_pkg::*;

  // WB stage copy of the access
  data_type_e             data_type_q;
  sign_ext_e              sign_ext_q;
  logic [1:0]             rdata_offset_q;
  logic                   data_we_q;

  logic [`LSU_DATA_W-1:0] rdata_q;     // raw first half, or last result
  lsu_word_u              resp_w;      // current response
  lsu_word_u              held_w;      // held word
  logic [`LSU_DATA_W-1:0] word_val;    // merged word
  logic [15:0]            half_lane;
  logic [7:0]             byte_lane;
  logic [`LSU_DATA_W-1:0] rdata_ext;   // final value for the register file

  // fill bit for the upper bits of a narrow load
  function automatic logic fill_bit(sign_ext_e mode, logic msb);
    case (mode)
      SEXT_ZERO: return 1'b0;
      SEXT_ONES: return 1'b1;
      default:   return msb;  // sign, code 11 too
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // WB control registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q    <= DT_WORD;
      sign_ext_q     <= SEXT_ZERO;
      rdata_offset_q <= 2'b00;
      data_we_q      <= 1'b0;
    end else if (ctrl_update_i) begin  // granted, wait for rvalid in WB
      data_type_q    <= data_type_ex_i;
      sign_ext_q     <= data_sign_ext_ex_i;
      rdata_offset_q <= addr_lsb_i;
      data_we_q      <= data_we_ex_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lane select

  assign resp_w = rdata_i;
  assign held_w = rdata_q;

  // split word: low bytes from the new word on top of the held high bytes
  always_comb begin
    case (rdata_offset_q)
      2'd0:    word_val = resp_w;
      2'd1:    word_val = {resp_w.b[0], held_w.b[3:1]};
      2'd2:    word_val = {resp_w.h[0], held_w.h[1]};
      default: word_val = {resp_w.b[2:0], held_w.b[3]};
    endcase
  end

  always_comb begin
    case (rdata_offset_q)
      2'd0:    half_lane = resp_w.h[0];
      2'd1:    half_lane = {resp_w.b[2], resp_w.b[1]};  // straddles both halves
      2'd2:    half_lane = resp_w.h[1];
      default: half_lane = {resp_w.b[0], held_w.b[3]};  // split half
    endcase
  end

  assign byte_lane = resp_w.b[rdata_offset_q];

  //////////////////////////////////////////////////////////////////////
  // extension

  always_comb begin
    case (data_type_q)
      DT_WORD: rdata_ext = word_val;
      DT_HALF: rdata_ext = {{16{fill_bit(sign_ext_q, half_lane[15])}}, half_lane};
      default: rdata_ext = {{24{fill_bit(sign_ext_q, byte_lane[7])}}, byte_lane};
    endcase
  end

  // first half of a split load is kept raw for the merge
  always_ff @(posedge clk) begin
    if (rvalid_i && !data_we_q) begin
      if (data_misaligned_ex_i || misaligned_i)
        rdata_q <= rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // live with the response, held afterwards
  assign rdata_ex_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

// ==== source/lsu_top.sv ====
// lsu top level
// joins request control and both aligners and drives the data bus

`include "lsu_params.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // EX stage
  input  logic                   data_req_ex_i,
  input  logic                   data_we_ex_i,
  input  lsu_pkg::data_type_e    data_type_ex_i,
  input  lsu_pkg::sign_ext_e     data_sign_ext_ex_i,
  input  logic [`LSU_DATA_W-1:0] data_wdata_ex_i,
  input  logic [1:0]             data_reg_offset_ex_i,
  input  logic [`LSU_ADDR_W-1:0] operand_a_ex_i,
  input  logic [`LSU_ADDR_W-1:0] operand_b_ex_i,
  input  logic                   addr_useincr_ex_i,
  input  logic                   data_misaligned_ex_i,
  output logic [`LSU_DATA_W-1:0] data_rdata_ex_o,
  output logic                   data_misaligned_o,
  output logic                   lsu_ready_ex_o,
  output logic                   lsu_ready_wb_o,
  output logic                   busy_o,

  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic [`LSU_ADDR_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i
);

  logic                   trans_valid;
  logic [`LSU_ADDR_W-1:0] trans_addr;   // word aligned on a second part
  logic [`LSU_BE_W-1:0]   trans_be;
  logic [`LSU_DATA_W-1:0] trans_wdata;
  logic                   ctrl_update;
  logic [1:0]             addr_lsb;     // original byte offset

  // second part uses operand a alone, its low bits keep the first offset
  assign addr_lsb = data_misaligned_ex_i ? operand_a_ex_i[1:0] : trans_addr[1:0];

  lsu_req_ctrl u_req_ctrl (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_req_ex_i        (data_req_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .gnt_i                (data_gnt_i),
    .rvalid_i             (data_rvalid_i),
    .addr_o               (trans_addr),
    .trans_valid_o        (trans_valid),
    .misaligned_o         (data_misaligned_o),
    .ready_ex_o           (lsu_ready_ex_o),
    .ready_wb_o           (lsu_ready_wb_o),
    .ctrl_update_o        (ctrl_update),
    .busy_o               (busy_o)
  );

  lsu_store_align u_store_align (
    .addr_lsb_i           (addr_lsb),
    .data_type_ex_i       (data_type_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .be_o                 (trans_be),
    .wdata_o              (trans_wdata)
  );

  lsu_load_align u_load_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .addr_lsb_i           (addr_lsb),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_i         (data_misaligned_o),
    .rvalid_i             (data_rvalid_i),
    .rdata_i              (data_rdata_i),
    .rdata_ex_o           (data_rdata_ex_o)
  );

  //////////////////////////////////////////////////////////////////////
  // bus side, EX holds its inputs until the grant so these stay stable
  assign data_req_o   = trans_valid;
  assign data_addr_o  = trans_addr;
  assign data_we_o    = data_we_ex_i;
  assign data_be_o    = trans_be;
  assign data_wdata_o = trans_wdata;

endmodule

// ==== dv/lsu_properties.sv ====
// lsu bus properties
// outstanding count limits and request sanity, bound into the request control

`include "lsu_params.svh"

module lsu_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`LSU_CNT_W-1:0]  cnt_q,
  input logic                   rvalid_i,
  input logic                   trans_valid_o,
  input logic [`LSU_ADDR_W-1:0] addr_o
);

  //////////////////////////////////////////////////////////////////////
  // outstanding transactions

  a_cnt_max : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `LSU_CNT_W'(`LSU_DEPTH))
    else $error("outstanding count above the allowed depth");

  // a response needs a granted request in flight
  a_rvalid_cnt : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (cnt_q != '0))
    else $error("rvalid seen with nothing outstanding");

  //////////////////////////////////////////////////////////////////////
  // request side

  a_req_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(trans_valid_o))
    else $error("bus request is unknown");

  a_addr_known : assert property (@(posedge clk) disable iff (!rst_n)
    trans_valid_o |-> !$isunknown(addr_o))  // address must be clean while requesting
    else $error("bus address unknown during a request");

endmodule

bind lsu_req_ctrl lsu_properties u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .cnt_q         (cnt_q),
  .rvalid_i      (rvalid_i),
  .trans_valid_o (trans_valid_o),
  .addr_o        (addr_o)
);

// ==== dv/lsu_tb.sv ====
// lsu testbench
// directed tests against a small bus memory with random grant and response delay

module lsu_tb;

  import lsu_pkg::*;

  localparam int CYCLE_LIMIT = 20000;  // far above the length of all tests
  localparam int MEM_WORDS   = 16;

  logic clk;
  logic rst_n;
  logic data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  data_type_e  data_type_ex_i;
  sign_ext_e   data_sign_ext_ex_i;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic [1:0]  data_reg_offset_ex_i;
  logic [31:0] data_rdata_ex_o;
  logic        data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;

  logic [31:0] mem [MEM_WORDS];      // bus memory
  logic [31:0] exp_mem [MEM_WORDS];  // expected contents
  logic [31:0] rsp_addr_q[$];        // granted requests awaiting rvalid
  logic        rsp_we_q[$];
  int          rsp_due_q[$];
  logic [31:0] load_results[$];      // load data seen with each load rvalid
  int          stall;                // grant delay still to go
  int          cycles;

  lsu_top i_dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // bus memory model

  always @(posedge clk) begin
    if (rst_n) begin
      // WB is free when nothing is in flight, otherwise only with a response
      check("ready_wb", (rsp_addr_q.size() == 0) ? 32'd1 : 32'(data_rvalid_i),
            32'(lsu_ready_wb_o));
      if (data_rvalid_i) begin
        if (!rsp_we_q[0]) load_results.push_back(data_rdata_ex_o);
        void'(rsp_addr_q.pop_front());
        void'(rsp_we_q.pop_front());
        void'(rsp_due_q.pop_front());
      end
      if (data_req_o && data_gnt_i) begin
        for (int i = 0; i < 4; i++)
          if (data_we_o && data_be_o[i]) mem[data_addr_o[5:2]][8*i +: 8] = data_wdata_o[8*i +: 8];
        rsp_addr_q.push_back(data_addr_o);
        rsp_we_q.push_back(data_we_o);
        rsp_due_q.push_back(cycles + 1 + int'($urandom % 2));  // 1 or 2 cycles later
        stall = int'($urandom % 3);
      end else if (data_req_o && stall > 0) begin
        stall = stall - 1;
      end
    end
  end

  always @(negedge clk) begin
    data_gnt_i = (stall == 0);
    if (rsp_due_q.size() > 0 && cycles >= rsp_due_q[0]) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = mem[rsp_addr_q[0][5:2]];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("error: simulation timed out after %0d cycles", cycles);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference helpers

  function automatic int access_bytes(data_type_e dt);
    case (dt)
      DT_WORD: return 4;
      DT_HALF: return 2;
      default: return 1;
    endcase
  endfunction

  function automatic logic [3:0] expected_be(data_type_e dt, logic [1:0] off, logic second);
    logic [3:0] be;
    int         k;
    k = int'(off);
    for (int i = 0; i < 4; i++) begin
      case (dt)
        DT_WORD: be[i] = second ? (i < k) : (i >= k);
        DT_HALF: be[i] = second ? (i == 0) : (i == k || i == k + 1);
        default: be[i] = (i == k);
      endcase
    end
    return be;
  endfunction

  // byte i of the result takes byte i-sh of the source
  function automatic logic [31:0] rotate_bytes(logic [31:0] v, logic [1:0] sh);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) r[8*i +: 8] = v[8*((i + 4 - int'(sh)) % 4) +: 8];
    return r;
  endfunction

  function automatic logic [31:0] read_bytes(logic [31:0] addr, int n);
    logic [31:0] r;
    logic [31:0] a;
    r = '0;
    for (int j = 0; j < n; j++) begin
      a = addr + 32'(j);
      r[8*j +: 8] = exp_mem[a[5:2]][8*int'(a[1:0]) +: 8];  // little endian
    end
    return r;
  endfunction

  function automatic logic [31:0] extend_load(logic [31:0] v, int n, sign_ext_e m);
    logic [31:0] r;
    logic        fill;
    r = v;
    case (m)
      SEXT_ZERO: fill = 1'b0;
      SEXT_ONES: fill = 1'b1;
      default:   fill = v[8*n-1];
    endcase
    for (int i = 8 * n; i < 32; i++) r[i] = fill;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drivers and checks

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic idle_inputs();
    data_req_ex_i        = 1'b0;
    data_we_ex_i         = 1'b0;
    data_type_ex_i       = DT_WORD;
    data_sign_ext_ex_i   = SEXT_ZERO;
    data_wdata_ex_i      = '0;
    data_reg_offset_ex_i = 2'd0;
    operand_a_ex_i       = '0;
    operand_b_ex_i       = '0;
    addr_useincr_ex_i    = 1'b0;
    data_misaligned_ex_i = 1'b0;
  endtask

  // hold one operation until EX accepts it, return what the bus saw
  task automatic do_op(input logic we, input data_type_e dt, input sign_ext_e se,
                       input logic [31:0] a, input logic [31:0] b, input logic useincr,
                       input logic [31:0] wd, input logic [1:0] roff, input logic second,
                       output logic mis, output logic [31:0] addr, output logic [3:0] be,
                       output logic [31:0] wdat);
    data_req_ex_i        = 1'b1;
    data_we_ex_i         = we;
    data_type_ex_i       = dt;
    data_sign_ext_ex_i   = se;
    data_wdata_ex_i      = wd;
    data_reg_offset_ex_i = roff;
    operand_a_ex_i       = a;
    operand_b_ex_i       = b;
    addr_useincr_ex_i    = useincr;
    data_misaligned_ex_i = second;
    @(posedge clk);
    while (!lsu_ready_ex_o) @(posedge clk);
    mis  = data_misaligned_o;
    addr = data_addr_o;
    be   = data_be_o;
    wdat = data_wdata_o;
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (busy_o) @(posedge clk);
    @(negedge clk);
  endtask

  // one access, split into two parts where it crosses a word
  task automatic run_access(input string name, input logic we, input data_type_e dt,
                            input sign_ext_e se, input logic [31:0] addr,
                            input logic [1:0] roff, input logic [31:0] wd);
    logic [1:0]  off;
    logic        split;
    int          n;
    logic        mis;
    logic [31:0] got_addr, got_wd, b_addr, next_addr;
    logic [3:0]  got_be;
    off       = addr[1:0];
    n         = access_bytes(dt);
    split     = (dt == DT_WORD && off != 2'd0) || (dt == DT_HALF && off == 2'd3);
    next_addr = {addr[31:2] + 30'd1, 2'b00};
    load_results.delete();
    do_op(we, dt, se, {addr[31:2], 2'b00}, {30'd0, off}, 1'b1, wd, roff, 1'b0,
          mis, got_addr, got_be, got_wd);
    check({name, " misaligned"}, 32'(split), 32'(mis));
    check({name, " addr"}, addr, got_addr);
    check({name, " be"}, 32'(expected_be(dt, off, 1'b0)), 32'(got_be));
    if (we) check({name, " wdata"}, rotate_bytes(wd, off - roff), got_wd);
    if (split) begin
      do_op(we, dt, se, addr + 32'd4, 32'd0, 1'b0, wd, roff, 1'b1, mis, got_addr, got_be, got_wd);
      check({name, " second misaligned"}, 32'd0, 32'(mis));
      check({name, " second addr"}, next_addr, got_addr);
      check({name, " second be"}, 32'(expected_be(dt, off, 1'b1)), 32'(got_be));
      if (we) check({name, " second wdata"}, rotate_bytes(wd, off - roff), got_wd);
    end
    wait_idle();
    if (we) begin
      for (int j = 0; j < n; j++) begin
        b_addr = addr + 32'(j);
        exp_mem[b_addr[5:2]][8*int'(b_addr[1:0]) +: 8] = wd[8*((int'(roff) + j) % 4) +: 8];
      end
      check({name, " memory"}, exp_mem[addr[5:2]], mem[addr[5:2]]);
      if (split) check({name, " next memory"}, exp_mem[next_addr[5:2]], mem[next_addr[5:2]]);
    end else if (load_results.size() == 0) begin
      $display("error: %s returned no load data", name);
      $display("*** FAILED ***");
      $fatal(1);
    end else begin
      check({name, " rdata"}, extend_load(read_bytes(addr, n), n, se), load_results[$]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests

  task automatic reset_test();
    check("reset data_req", 32'd0, 32'(data_req_o));
    check("reset busy", 32'd0, 32'(busy_o));
    check("reset misaligned", 32'd0, 32'(data_misaligned_o));
    check("reset ready_ex", 32'd1, 32'(lsu_ready_ex_o));
    check("reset ready_wb", 32'd1, 32'(lsu_ready_wb_o));
  endtask

  task automatic store_test();
    run_access("store word", 1'b1, DT_WORD, SEXT_ZERO, 32'd8, 2'($urandom % 4), $urandom);
    for (int k = 0; k < 3; k++)
      run_access($sformatf("store half off %0d", k), 1'b1, DT_HALF, SEXT_ZERO,
                 32'd12 + 32'(k), 2'($urandom % 4), $urandom);
    for (int k = 0; k < 4; k++)
      run_access($sformatf("store byte off %0d", k), 1'b1, DT_BYTE, SEXT_ZERO,
                 32'd16 + 32'(k), 2'($urandom % 4), $urandom);
  endtask

  task automatic load_test();
    sign_ext_e se;
    mem[4]     = 32'hF123_9A45;  // lanes with the top bit set and clear
    mem[5]     = 32'h6ED7_18B3;
    exp_mem[4] = mem[4];
    exp_mem[5] = mem[5];
    for (int w = 4; w < 6; w++) begin
      for (int m = 0; m < 4; m++) begin
        se = sign_ext_e'(2'(m));  // code 3 acts as sign
        for (int k = 0; k < 3; k++)
          run_access($sformatf("load half w%0d off %0d mode %0d", w, k, m), 1'b0, DT_HALF,
                     se, 32'(4 * w + k), 2'd0, 32'd0);
        for (int k = 0; k < 4; k++)
          run_access($sformatf("load byte w%0d off %0d mode %0d", w, k, m), 1'b0, DT_BYTE,
                     se, 32'(4 * w + k), 2'd0, 32'd0);
      end
    end
  endtask

  task automatic misaligned_test();
    for (int k = 1; k < 4; k++)
      run_access($sformatf("split word store off %0d", k), 1'b1, DT_WORD, SEXT_ZERO,
                 32'd24 + 32'(k), 2'd0, $urandom);
    run_access("split half store", 1'b1, DT_HALF, SEXT_ZERO, 32'd35, 2'd0, $urandom);
    for (int k = 1; k < 4; k++)
      run_access($sformatf("split word load off %0d", k), 1'b0, DT_WORD, SEXT_SIGN,
                 32'd40 + 32'(k), 2'd0, 32'd0);
    for (int m = 0; m < 4; m++)
      run_access($sformatf("split half load mode %0d", m), 1'b0, DT_HALF,
                 sign_ext_e'(2'(m)), 32'd47, 2'd0, 32'd0);
  endtask

  // loads issued back to back, no wait between them
  task automatic pipeline_test();
    logic [31:0] exp_q[$];
    logic [31:0] addr, got_addr, got_wd;
    logic [3:0]  got_be;
    logic        mis;
    data_type_e  dt;
    sign_ext_e   se;
    int          n;
    load_results.delete();
    for (int i = 0; i < 16; i++) begin
      case ($urandom % 3)
        0:       dt = DT_WORD;
        1:       dt = DT_HALF;
        default: dt = DT_BYTE;
      endcase
      n    = access_bytes(dt);
      addr = 32'($urandom % 16) * 32'd4 + 32'(n) * 32'($urandom % (4 / n));  // aligned only
      se   = sign_ext_e'(2'($urandom % 4));
      exp_q.push_back(extend_load(read_bytes(addr, n), n, se));
      do_op(1'b0, dt, se, addr, 32'd0, 1'b0, 32'd0, 2'd0, 1'b0, mis, got_addr, got_be, got_wd);
    end
    // the cycle after the last response nothing is left in flight
    while (load_results.size() < exp_q.size()) @(negedge clk);
    check("pipeline busy", 32'd0, 32'(busy_o));
    wait_idle();
    check("pipeline count", 32'(exp_q.size()), 32'(load_results.size()));
    for (int i = 0; i < exp_q.size(); i++)
      check($sformatf("pipeline load %0d", i), exp_q[i], load_results[i]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    void'($urandom(6));
    clk           = 1'b0;
    rst_n         = 1'b0;
    cycles        = 0;
    stall         = 0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    idle_inputs();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = (32'(i) * 32'h1357_9BDF) ^ 32'hA5C3_1E7B;  // differs per address
      exp_mem[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_test();
    store_test();
    load_test();
    misaligned_test();
    pipeline_test();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/lsu_pkg.sv
source/lsu_req_ctrl.sv
source/lsu_store_align.sv
source/lsu_load_align.sv
source/lsu_top.sv
dv/lsu_properties.sv
dv/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lsu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module lsu_tb -f vlog.f -o lsu_sim

./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log || ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
